// File: hdl/lc_ctrl_config.svh
// Build-wide sizes for the life cycle sync subsystem
// Word width and the number of buffered debug enable copies

`ifndef LC_CTRL_CONFIG_SVH
`define LC_CTRL_CONFIG_SVH

//////////////////////////////////////////////////
// Life cycle word
//////////////////////////////////////////////////

// Bits in one multibit life cycle signal
`define LC_TX_WIDTH 4

//////////////////////////////////////////////////
// Fan-out
//////////////////////////////////////////////////

// Copy 0 feeds the access gate, copy 1 leaves the top
`define LC_DBG_COPIES 2

`endif

// File: hdl/lc_ctrl_pkg.sv
// Life cycle word type with its On and Off patterns
// Strict, loose and validity test functions

`include "lc_ctrl_config.svh"

package lc_ctrl_pkg;

  //////////////////////////////////////////////////
  // Encoding
  //////////////////////////////////////////////////

  // Only two patterns are legal, the rest are invalid
  // On and Off are bitwise complements so a single flip never maps one to the other
  typedef enum logic [`LC_TX_WIDTH-1:0] {
    LcOn  = 4'b1010,
    LcOff = 4'b0101
  } lc_tx_t;

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  // True only for the exact On pattern
  // Used for enables, anything else denies
  function automatic logic lc_tx_test_true_strict(lc_tx_t val);
    return (val == LcOn);
  endfunction

  // True only for the exact Off pattern
  // Negated, this treats every non-Off value as asserted
  function automatic logic lc_tx_test_false_loose(lc_tx_t val);
    return (val == LcOff);
  endfunction

  // Legal encoding check
  function automatic logic lc_tx_is_valid(lc_tx_t val);
    logic is_on;
    logic is_off;
    is_on  = (val == LcOn);
    is_off = (val == LcOff);
    return (is_on || is_off);
  endfunction

endpackage

// File: hdl/lc_flop_2sync.sv
// Two-stage synchronizer flop with a parameterized reset value

`timescale 1ns/1ps

`include "lc_ctrl_config.svh"

module lc_flop_2sync #(
  // Data width
  parameter int unsigned            Width      = `LC_TX_WIDTH,
  // Value both stages take during reset
  parameter logic [Width-1:0]       ResetValue = '0
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic [Width-1:0] d_i,
  output logic [Width-1:0] q_o
);

  // First stage may go metastable, second stage settles it
  logic [Width-1:0] stage1_q;
  logic [Width-1:0] stage2_q;

  //////////////////////////////////////////////////
  // Synchronizer stages
  //////////////////////////////////////////////////

  // Asynchronous data enters the local domain only here
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage1_q <= ResetValue;
      stage2_q <= ResetValue;
    end else begin
      stage1_q <= d_i;
      stage2_q <= stage1_q;
    end
  end

  // Output is the input from two rising edges earlier
  assign q_o = stage2_q;

endmodule

// File: hdl/lc_sync.sv
// Life cycle signal synchronizer
// Optional bypass and several separately buffered output copies

`timescale 1ns/1ps

`include "lc_ctrl_config.svh"

module lc_sync
  import lc_ctrl_pkg::*;
#(
  // Number of distinct output copies
  parameter int unsigned NumCopies      = 1,
  // Set: two flop stages, clear: same clock domain, no flops
  parameter bit          AsyncOn        = 1'b1,
  // Set: reset to On, clear: reset to Off
  parameter bit          ResetValueIsOn = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lc_tx_t                 lc_en_i,
  output lc_tx_t [NumCopies-1:0] lc_en_o
);

  // Escalation style users want On here so reset fails safe
  localparam lc_tx_t LcResetValue = ResetValueIsOn ? LcOn : LcOff;

  // Synchronized word, before the copies split off
  logic [`LC_TX_WIDTH-1:0] lc_en;

  //////////////////////////////////////////////////
  // Synchronizer or bypass
  //////////////////////////////////////////////////

  if (AsyncOn) begin : gen_flops
    // Two cycles of latency
    lc_flop_2sync #(
      .Width      (`LC_TX_WIDTH),
      .ResetValue (`LC_TX_WIDTH'(LcResetValue))
    ) u_flop_2sync (
      .clk_i  (clk_i),
      .rst_ni (rst_ni),
      .d_i    (lc_en_i),
      .q_o    (lc_en)
    );
  end else begin : gen_no_flops
    // Sender already in this domain, zero latency
    // Clock and reset are left unloaded in this case
    assign lc_en = lc_en_i;
  end

  //////////////////////////////////////////////////
  // Output copies
  //////////////////////////////////////////////////

  // One assignment per bit and copy
  // Keeps each copy its own net so consumers do not share a driver
  for (genvar j = 0; j < NumCopies; j++) begin : gen_copies
    logic [`LC_TX_WIDTH-1:0] lc_en_out;

    for (genvar k = 0; k < `LC_TX_WIDTH; k++) begin : gen_bits
      assign lc_en_out[k] = lc_en[k];
    end

    // Back to the enum type on the way out
    assign lc_en_o[j] = lc_tx_t'(lc_en_out);
  end

endmodule

// File: hdl/lc_access_gate.sv
// Debug and DFT request gating on synchronized life cycle enables
// Registered grants, escalation status and a sticky invalid flag

`timescale 1ns/1ps

module lc_access_gate
  import lc_ctrl_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  // Synchronized life cycle words
  input  lc_tx_t lc_dft_en_i,
  input  lc_tx_t lc_hw_debug_en_i,
  input  lc_tx_t lc_escalate_en_i,
  // Local request levels
  input  logic   dbg_req_i,
  input  logic   dft_req_i,
  // Registered results
  output logic   dbg_grant_o,
  output logic   dft_grant_o,
  output logic   escalated_o,
  output logic   invalid_o
);

  // Decoded conditions, all combinational
  logic esc_active;
  logic dbg_en_on;
  logic dft_en_on;
  logic any_invalid;

  // Next-state values for the grants
  logic dbg_grant_d;
  logic dft_grant_d;

  // Output registers
  logic dbg_grant_q;
  logic dft_grant_q;
  logic escalated_q;
  logic invalid_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  // Fail safe, anything but exact Off counts as escalation
  assign esc_active = !lc_tx_test_false_loose(lc_escalate_en_i);

  // Enables are strict, only exact On opens the gate
  assign dbg_en_on = lc_tx_test_true_strict(lc_hw_debug_en_i);
  assign dft_en_on = lc_tx_test_true_strict(lc_dft_en_i);

  // Any word outside On and Off
  assign any_invalid = !lc_tx_is_valid(lc_dft_en_i)      ||
                       !lc_tx_is_valid(lc_hw_debug_en_i) ||
                       !lc_tx_is_valid(lc_escalate_en_i);

  // Request, strict enable, and no escalation
  assign dbg_grant_d = dbg_req_i && dbg_en_on && !esc_active;
  assign dft_grant_d = dft_req_i && dft_en_on && !esc_active;

  //////////////////////////////////////////////////
  // Output registers
  //////////////////////////////////////////////////

  // One cycle from request and words to outputs
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dbg_grant_q <= 1'b0;
      dft_grant_q <= 1'b0;
      // Escalation synchronizer resets to On, match it here
      escalated_q <= 1'b1;
      invalid_q   <= 1'b0;
    end else begin
      dbg_grant_q <= dbg_grant_d;
      dft_grant_q <= dft_grant_d;
      escalated_q <= esc_active;
      // Sticky, only reset clears it
      invalid_q   <= invalid_q | any_invalid;
    end
  end

  assign dbg_grant_o = dbg_grant_q;
  assign dft_grant_o = dft_grant_q;
  assign escalated_o = escalated_q;
  assign invalid_o   = invalid_q;

endmodule

// File: hdl/lc_ctrl_sync_top.sv
// Life cycle sync subsystem top level
// Three enable synchronizers feeding the debug and DFT access gate

`timescale 1ns/1ps

`include "lc_ctrl_config.svh"

module lc_ctrl_sync_top
  import lc_ctrl_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  // Life cycle words from the other clock domain
  input  lc_tx_t lc_dft_en_i,
  input  lc_tx_t lc_hw_debug_en_i,
  input  lc_tx_t lc_escalate_en_i,
  // Local request levels
  input  logic   dbg_req_i,
  input  logic   dft_req_i,
  // Synchronized debug enable for other consumers
  output lc_tx_t lc_hw_debug_en_o,
  // Gate results
  output logic   dbg_grant_o,
  output logic   dft_grant_o,
  output logic   escalated_o,
  output logic   invalid_o
);

  // Synchronized copies
  lc_tx_t [0:0]                dft_en_sync;
  lc_tx_t [`LC_DBG_COPIES-1:0] hw_debug_en_sync;
  lc_tx_t [0:0]                escalate_en_sync;

  //////////////////////////////////////////////////
  // Synchronizers
  //////////////////////////////////////////////////

  // DFT enable, resets to Off
  lc_sync #(
    .NumCopies      (1),
    .AsyncOn        (1'b1),
    .ResetValueIsOn (1'b0)
  ) u_sync_dft_en (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .lc_en_i (lc_dft_en_i),
    .lc_en_o (dft_en_sync)
  );

  // Debug enable, resets to Off
  // Copy 0 to the gate, copy 1 out of the top
  lc_sync #(
    .NumCopies      (`LC_DBG_COPIES),
    .AsyncOn        (1'b1),
    .ResetValueIsOn (1'b0)
  ) u_sync_hw_debug_en (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .lc_en_i (lc_hw_debug_en_i),
    .lc_en_o (hw_debug_en_sync)
  );

  // Escalation, resets to On so nothing is granted until Off arrives
  lc_sync #(
    .NumCopies      (1),
    .AsyncOn        (1'b1),
    .ResetValueIsOn (1'b1)
  ) u_sync_escalate_en (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .lc_en_i (lc_escalate_en_i),
    .lc_en_o (escalate_en_sync)
  );

  // Two cycles from input to this port
  assign lc_hw_debug_en_o = hw_debug_en_sync[1];

  //////////////////////////////////////////////////
  // Access gate
  //////////////////////////////////////////////////

  // One more register stage, three cycles input to grant
  lc_access_gate u_access_gate (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lc_dft_en_i      (dft_en_sync[0]),
    .lc_hw_debug_en_i (hw_debug_en_sync[0]),
    .lc_escalate_en_i (escalate_en_sync[0]),
    .dbg_req_i        (dbg_req_i),
    .dft_req_i        (dft_req_i),
    .dbg_grant_o      (dbg_grant_o),
    .dft_grant_o      (dft_grant_o),
    .escalated_o      (escalated_o),
    .invalid_o        (invalid_o)
  );

endmodule

// File: testbench/lc_ctrl_sync_assert.sv
// Concurrent checks on the life cycle sync top level
// Bound into every lc_ctrl_sync_top instance

`timescale 1ns/1ps

module lc_ctrl_sync_assert
  import lc_ctrl_pkg::*;
(
  input logic   clk_i,
  input logic   rst_ni,
  input logic   dbg_req_i,
  input logic   dft_req_i,
  input lc_tx_t lc_hw_debug_en_i,
  input logic   dbg_grant_i,
  input logic   dft_grant_i,
  input logic   escalated_i,
  input logic   invalid_i
);

  //////////////////////////////////////////////////
  // Gate rules
  //////////////////////////////////////////////////

  // Grants and escalation come from the same decode, never both high
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dbg_grant_i || dft_grant_i) |-> !escalated_i)
    else $error("grant asserted while escalated");

  // Request is registered alongside the grant
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_grant_i |-> $past(dbg_req_i))
    else $error("debug grant without an earlier debug request");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    dft_grant_i |-> $past(dft_req_i))
    else $error("DFT grant without an earlier DFT request");

  // Sticky flag
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(invalid_i) |-> invalid_i)
    else $error("invalid flag dropped outside reset");

  //////////////////////////////////////////////////
  // X checks
  //////////////////////////////////////////////////

  assert property (@(posedge clk_i)
    !$isunknown({lc_hw_debug_en_i, dbg_grant_i, dft_grant_i, escalated_i, invalid_i}))
    else $error("unknown value on a top level output");

endmodule

bind lc_ctrl_sync_top lc_ctrl_sync_assert u_sync_assert (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .dbg_req_i        (dbg_req_i),
  .dft_req_i        (dft_req_i),
  .lc_hw_debug_en_i (lc_hw_debug_en_o),
  .dbg_grant_i      (dbg_grant_o),
  .dft_grant_i      (dft_grant_o),
  .escalated_i      (escalated_o),
  .invalid_i        (invalid_o)
);

// File: testbench/tb_lc_ctrl_sync.sv
// Testbench for the life cycle sync top level
// Xorshift stimulus, reference model with compare process, cycle timeout

`timescale 1ns/1ps

module tb_lc_ctrl_sync
  import lc_ctrl_pkg::*;
;

  // Legal patterns, straight from the encoding rules
  localparam logic [3:0] ON_PAT  = 4'b1010;
  localparam logic [3:0] OFF_PAT = 4'b0101;
  // Roughly 400 cycles of stimulus, plus slack
  localparam int CYCLE_LIMIT = 500;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  lc_tx_t      lc_dft_en;
  lc_tx_t      lc_hw_debug_en;
  lc_tx_t      lc_escalate_en;
  logic        dbg_req;
  logic        dft_req;
  lc_tx_t      lc_hw_debug_en_out;
  logic        dbg_grant;
  logic        dft_grant;
  logic        escalated;
  logic        invalid;
  logic [31:0] rng_state;
  int          cycle_count = 0;

  // Index 0 holds the sample of the latest edge
  logic [3:0]  dft_hist [0:2];
  logic [3:0]  dbg_hist [0:2];
  logic [3:0]  esc_hist [0:2];
  logic [3:0]  expected;
  logic        model_invalid;

  lc_ctrl_sync_top dut_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lc_dft_en_i      (lc_dft_en),
    .lc_hw_debug_en_i (lc_hw_debug_en),
    .lc_escalate_en_i (lc_escalate_en),
    .dbg_req_i        (dbg_req),
    .dft_req_i        (dft_req),
    .lc_hw_debug_en_o (lc_hw_debug_en_out),
    .dbg_grant_o      (dbg_grant),
    .dft_grant_o      (dft_grant),
    .escalated_o      (escalated),
    .invalid_o        (invalid)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Three out of four picks are On
  function automatic logic [3:0] pick_enable(input logic [1:0] sel);
    return (sel != 2'b00) ? ON_PAT : OFF_PAT;
  endfunction

  // One flipped bit turns either legal pattern illegal
  function automatic logic [3:0] make_invalid(input logic [3:0] raw);
    if (raw == ON_PAT || raw == OFF_PAT) begin
      return raw ^ 4'b0001;
    end
    return raw;
  endfunction

  // {dbg_grant, dft_grant, escalated, word invalid}
  function automatic logic [3:0] reference_gate(input logic [3:0] dft, input logic [3:0] dbg,
                                                input logic [3:0] esc, input logic dbg_r,
                                                input logic dft_r);
    logic esc_on;
    logic bad;
    esc_on = (esc != OFF_PAT);
    bad = (dft != ON_PAT && dft != OFF_PAT) || (dbg != ON_PAT && dbg != OFF_PAT) ||
          (esc != ON_PAT && esc != OFF_PAT);
    return {dbg_r && (dbg == ON_PAT) && !esc_on, dft_r && (dft == ON_PAT) && !esc_on,
            esc_on, bad};
  endfunction

  task automatic check_value(input string what, input logic [3:0] actual,
                             input logic [3:0] want);
    if (actual !== want) begin
      $display("ERR %0t: %s is %0h, expected %0h", $time, what, actual, want);
      $display("sim failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Valid words on the enables, escalation word given by the caller
  task automatic drive_valid_cycle(input logic [3:0] esc_word);
    logic [31:0] r;
    rng_state = xorshift32(rng_state);
    r = rng_state;
    @(negedge clk_i);
    lc_dft_en      = lc_tx_t'(pick_enable(r[1:0]));
    lc_hw_debug_en = lc_tx_t'(pick_enable(r[3:2]));
    lc_escalate_en = lc_tx_t'(esc_word);
    dbg_req        = r[4] | r[5];
    dft_req        = r[6] | r[7];
  endtask

  // One word in four cycles gets an illegal pattern
  task automatic drive_invalid_cycle();
    logic [31:0] r;
    logic [3:0]  bad;
    drive_valid_cycle(OFF_PAT);
    r = rng_state;
    bad = make_invalid(r[19:16]);
    if (r[11:10] == 2'b00) begin
      case (r[13:12])
        2'd0:    lc_dft_en      = lc_tx_t'(bad);
        2'd1:    lc_hw_debug_en = lc_tx_t'(bad);
        default: lc_escalate_en = lc_tx_t'(bad);
      endcase
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////

  // Inputs sampled at the edge, outputs checked 1 ns later
  initial begin
    forever begin
      @(posedge clk_i);
      if (!rst_ni) begin
        for (int i = 0; i < 3; i++) begin
          dft_hist[i] = OFF_PAT;
          dbg_hist[i] = OFF_PAT;
          esc_hist[i] = ON_PAT;
        end
        model_invalid = 1'b0;
      end else begin
        for (int i = 2; i > 0; i--) begin
          dft_hist[i] = dft_hist[i-1];
          dbg_hist[i] = dbg_hist[i-1];
          esc_hist[i] = esc_hist[i-1];
        end
        dft_hist[0] = lc_dft_en;
        dbg_hist[0] = lc_hw_debug_en;
        esc_hist[0] = lc_escalate_en;
      end
      // Gate sees words from two edges back and the current requests
      expected = reference_gate(dft_hist[2], dbg_hist[2], esc_hist[2], dbg_req, dft_req);
      model_invalid = model_invalid | (rst_ni & expected[0]);
      #1;
      check_value("lc_hw_debug_en_o", lc_hw_debug_en_out, dbg_hist[1]);
      check_value("dbg_grant_o", 4'(dbg_grant), 4'(expected[3]));
      check_value("dft_grant_o", 4'(dft_grant), 4'(expected[2]));
      check_value("escalated_o", 4'(escalated), 4'(expected[1]));
      check_value("invalid_o", 4'(invalid), 4'(model_invalid));
    end
  end

  // Timeout
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("sim failed");
      $fatal(1, "Timeout, the stimulus did not finish within %0d cycles", CYCLE_LIMIT);
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  initial begin
    rst_ni         = 1'b0;
    lc_dft_en      = LcOff;
    lc_hw_debug_en = LcOff;
    lc_escalate_en = LcOff;
    dbg_req        = 1'b0;
    dft_req        = 1'b0;
    rng_state      = 32'hc288_eb0f;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    // Escalated drops once Off has crossed
    repeat (4) drive_valid_cycle(OFF_PAT);
    check_value("escalated_o after release", 4'(escalated), 4'b0);
    // Normal operation
    repeat (200) drive_valid_cycle(OFF_PAT);
    // Escalation blocks every grant
    repeat (50) drive_valid_cycle(ON_PAT);
    repeat (20) drive_valid_cycle(OFF_PAT);
    // Illegal words, escalation included
    repeat (100) drive_invalid_cycle();
    repeat (3) drive_valid_cycle(OFF_PAT);
    check_value("invalid_o held", 4'(invalid), 4'b1);
    // Only reset clears the flag
    apply_reset();
    repeat (20) drive_valid_cycle(OFF_PAT);
    repeat (2) @(negedge clk_i);
    $display("sim passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+hdl
hdl/lc_ctrl_pkg.sv
hdl/lc_flop_2sync.sv
hdl/lc_sync.sv
hdl/lc_access_gate.sv
hdl/lc_ctrl_sync_top.sv
testbench/lc_ctrl_sync_assert.sv
testbench/tb_lc_ctrl_sync.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_lc_ctrl_sync
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
